// File: build.f
music_pkg.sv
song_rom.sv
song_reader.sv
note_player.sv
tone_gen.sv
music_player.sv
tb_music_player.sv

// File: music_pkg.sv
`default_nettype none

package music_pkg;

	// song select and word address widths
	localparam int SONG_W = 2;
	localparam int ADDR_W = 5;

	// field widths of one note word
	localparam int NOTE_W = 6;
	localparam int DUR_W = 6;

	// one ROM word, note 0 is a rest, duration counts beats
	typedef struct packed {
		logic [NOTE_W-1:0] note;
		logic [DUR_W-1:0] duration;
	} note_word_t;

	// song reader FSM states
	typedef enum logic [2:0] {
		IDLE,
		FETCH,
		SEND,
		WAIT_NOTE,
		ADVANCE
	} reader_state_t;

	// song content rule, shared by the ROM and the testbench
	function automatic note_word_t song_word(input logic [SONG_W-1:0] song,
			input logic [ADDR_W-1:0] addr);
		note_word_t w;
		int unsigned n;
		n = (32'(song) * 7 + 32'(addr) * 3) % 48 + 1;
		// every eighth word is a rest
		w.note = (addr[2:0] == 3'd7) ? '0 : NOTE_W'(n);
		// one to four beats, cycling with the address
		w.duration = DUR_W'(addr[1:0]) + DUR_W'(1);
		return w;
	endfunction

endpackage

`default_nettype wire

// File: music_player.sv
`timescale 1ns/10ps
`default_nettype none

module music_player #(
	parameter int BEAT_DIV = 4,
	parameter int TONE_DIV = 1
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic play,
	input wire logic [music_pkg::SONG_W-1:0] song,
	output music_pkg::note_word_t note_word,
	output logic new_note,
	output logic song_done,
	output logic note_done,
	output logic tone
);

	import music_pkg::*;

	logic [SONG_W+ADDR_W-1:0] rom_addr;
	note_word_t rom_data;
	logic active;
	logic sounding;
	logic [NOTE_W-1:0] note;

	// decode, address walk and note fetch
	song_reader u_reader (
		.clk(clk),
		.rst_n(rst_n),
		.play(play),
		.song(song),
		.note_done(note_done),
		.rom_addr(rom_addr),
		.rom_data(rom_data),
		.note_word(note_word),
		.new_note(new_note),
		.song_done(song_done)
	);

	song_rom u_rom (
		.clk(clk),
		.addr(rom_addr),
		.dout(rom_data)
	);

	// execute, beat timing of each note
	note_player #(
		.BEAT_DIV(BEAT_DIV)
	) u_player (
		.clk(clk),
		.rst_n(rst_n),
		.play(play),
		.note_word(note_word),
		.new_note(new_note),
		.note_done(note_done),
		.active(active),
		.sounding(sounding),
		.note(note)
	);

	// result, square wave out
	tone_gen #(
		.TONE_DIV(TONE_DIV)
	) u_tone (
		.clk(clk),
		.rst_n(rst_n),
		.sounding(sounding),
		.note(note),
		.tone(tone)
	);

	// reader never hands over a word while the player is still busy
	a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		new_note |-> !active);

endmodule

`default_nettype wire

// File: note_player.sv
`timescale 1ns/10ps
`default_nettype none

module note_player #(
	parameter int BEAT_DIV = 4
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic play,
	input wire music_pkg::note_word_t note_word,
	input wire logic new_note,
	output logic note_done,
	output logic active,
	output logic sounding,
	output logic [music_pkg::NOTE_W-1:0] note
);

	import music_pkg::*;

	// at least one bit even for one clock per beat
	localparam int DIV_W = (BEAT_DIV > 1) ? $clog2(BEAT_DIV) : 1;

	// note being played
	note_word_t cur;
	// clocks inside the current beat
	logic [DIV_W-1:0] div_cnt;
	// beats already elapsed
	logic [DUR_W-1:0] beat_cnt;
	logic beat_end;

	assign beat_end = (div_cnt == DIV_W'(BEAT_DIV - 1));

	// last clock of the last beat, only while play is held
	assign note_done = active && play && beat_end &&
		(beat_cnt == cur.duration - DUR_W'(1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			div_cnt <= '0;
			beat_cnt <= '0;
		end else if (new_note) begin
			// counting restarts with every new word
			active <= 1'b1;
			div_cnt <= '0;
			beat_cnt <= '0;
		end else if (active && play) begin
			if (note_done)
				active <= 1'b0;
			if (beat_end) begin
				div_cnt <= '0;
				beat_cnt <= beat_cnt + DUR_W'(1);
			end else begin
				div_cnt <= div_cnt + DIV_W'(1);
			end
		end
		// play low leaves both counters frozen
	end

	// payload, loaded with the strobe
	always_ff @(posedge clk) begin
		if (new_note)
			cur <= note_word;
	end

	assign note = cur.note;

	// rests and pauses stay silent
	assign sounding = active && play && (cur.note != '0);

	// a zero-beat word would never finish
	a_dur_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		new_note |-> note_word.duration != '0);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the design and testbench with Verilator, run it and judge the log
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_music_player -f build.f \
	> build.log 2>&1 \
	&& ./obj_dir/Vtb_music_player > sim.log 2>&1 \
	|| echo "build or simulation step returned an error, see build.log" >> sim.log
cat sim.log
# the run counts as good only if the log carries the pass line
grep -q "All tests passed" sim.log \
	&& echo "simulation PASSED" \
	|| { echo "simulation FAILED"; exit 1; }

// File: song_reader.sv
`timescale 1ns/10ps
`default_nettype none

module song_reader (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic play,
	input wire logic [music_pkg::SONG_W-1:0] song,
	input wire logic note_done,
	output logic [music_pkg::SONG_W+music_pkg::ADDR_W-1:0] rom_addr,
	input wire music_pkg::note_word_t rom_data,
	output music_pkg::note_word_t note_word,
	output logic new_note,
	output logic song_done
);

	import music_pkg::*;

	reader_state_t state;
	reader_state_t state_nxt;

	// song select latched at song start
	logic [SONG_W-1:0] song_q;
	// word address inside the song
	logic [ADDR_W-1:0] addr;
	// word held for the player once the strobe is gone
	note_word_t word_q;
	logic last_addr;

	assign last_addr = (addr == '1);

	// ROM always sees the latched song
	assign rom_addr = {song_q, addr};

	always_comb begin
		state_nxt = state;
		case (state)
			// wait for play and latch the song select on the way out
			IDLE:
				if (play)
					state_nxt = FETCH;
			// ROM read in flight
			FETCH:
				state_nxt = SEND;
			// word is valid on rom_data and strobes to the player
			SEND:
				state_nxt = WAIT_NOTE;
			// player is timing the note
			WAIT_NOTE:
				if (note_done)
					state_nxt = ADVANCE;
			// step the address and go back to idle at the end of the song
			ADVANCE:
				state_nxt = last_addr ? IDLE : FETCH;
			default:
				state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			song_q <= '0;
			addr <= '0;
		end else begin
			state <= state_nxt;
			// a mid-song change of select waits for the next start
			if (state == IDLE && play)
				song_q <= song;
			// wraps from 31 back to 0 at the end of the song
			if (state == ADVANCE)
				addr <= addr + ADDR_W'(1);
		end
	end

	// payload register captures the ROM word during SEND
	always_ff @(posedge clk) begin
		if (state == SEND)
			word_q <= rom_data;
	end

	// during SEND the word comes straight from the ROM
	assign note_word = (state == SEND) ? rom_data : word_q;

	assign new_note = (state == SEND);
	assign song_done = (state == ADVANCE) && last_addr;

	// the player only finishes a note the reader is waiting on
	a_done_in_wait: assert property (@(posedge clk) disable iff (!rst_n)
		note_done |-> state == WAIT_NOTE);

endmodule

`default_nettype wire

// File: song_rom.sv
`timescale 1ns/10ps
`default_nettype none

module song_rom (
	input wire logic clk,
	input wire logic [music_pkg::SONG_W+music_pkg::ADDR_W-1:0] addr,
	output music_pkg::note_word_t dout
);

	import music_pkg::*;

	// four songs of 32 words each
	localparam int DEPTH = 2 ** (SONG_W + ADDR_W);

	note_word_t rom_table [DEPTH];

	// table contents fixed at elaboration
	// upper address bits pick the song, lower bits the word
	for (genvar i = 0; i < DEPTH; i++) begin : g_fill
		assign rom_table[i] = song_word(SONG_W'(i >> ADDR_W), ADDR_W'(i));
	end

	// registered read, data one clock after the address
	always_ff @(posedge clk) begin
		dout <= rom_table[addr];
	end

endmodule

`default_nettype wire

// File: tb_music_player.sv
`timescale 1ns/10ps
`default_nettype none

module tb_music_player;

	import music_pkg::*;

	localparam int BEAT_DIV = 4;
	localparam int TONE_DIV = 1;
	localparam int NUM_TESTS = 4;
	localparam int WORDS = 32;
	localparam int MAX_PAUSE = 12;
	localparam int IDLE_CYCLES = 20;
	localparam int RESET_CYCLES = 8;

	// per table row the song to play, the paused word and an optional mid-song switch
	typedef struct packed {
		logic [SONG_W-1:0] song;
		logic [ADDR_W-1:0] pause_word;
		logic switch_en;
		logic [SONG_W-1:0] switch_to;
	} stim_t;

	logic clk;
	logic rst_n;
	logic play;
	logic [SONG_W-1:0] song;
	note_word_t note_word;
	logic new_note;
	logic song_done;
	logic note_done;
	logic tone;
	stim_t stim_table [NUM_TESTS];
	int err_count = 0;
	int check_count = 0;
	int fail_count = 0;

	music_player #(
		.BEAT_DIV(BEAT_DIV),
		.TONE_DIV(TONE_DIV)
	) dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.play(play),
		.song(song),
		.note_word(note_word),
		.new_note(new_note),
		.song_done(song_done),
		.note_done(note_done),
		.tone(tone)
	);

	// 40 ns clock
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reference note word built from the song content rule
	function automatic logic [11:0] expected_word(input int s, input int a);
		int n;
		int d;
		n = (a % 8 == 7) ? 0 : (s * 7 + a * 3) % 48 + 1;
		d = a % 4 + 1;
		return {n[5:0], d[5:0]};
	endfunction

	task automatic check_val(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		check_count++;
		if (actual !== expected) begin
			err_count++;
			$display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, actual,
				expected);
		end
	endtask

	task automatic report(input int num, input string label, input int errs_before);
		if (err_count == errs_before) begin
			$display("test %0d, %s: ok", num, label);
		end else begin
			fail_count++;
			$display("test %0d, %s: FAILED, %0d errors", num, label, err_count - errs_before);
		end
	endtask

	// inputs change on the rising edge and outputs are read on the falling edge
	task automatic next_cycle(input logic play_val, input logic [SONG_W-1:0] song_val);
		@(posedge clk);
		play <= play_val;
		song <= song_val;
		@(negedge clk);
	endtask

	// sample n counts falling edges from the first one that sees play high
	task automatic run_entry(input int idx);
		stim_t st;
		string label;
		logic [11:0] ew;
		logic [SONG_W-1:0] song_nxt;
		logic play_nxt;
		logic snd_exp;
		logic snd_prev;
		logic finished;
		int e0;
		int n;
		int pass;
		int passes;
		int w;
		int cur_song;
		int exp_nn;
		int s;
		int done_exp;
		int sd_exp;
		int p_start;
		int p_len;
		int half;
		int note_val;
		int run_start;
		int dur;
		st = stim_table[idx];
		label = $sformatf("song %0d, pause in word %0d, switch %0d to song %0d",
			st.song, st.pause_word, st.switch_en, st.switch_to);
		e0 = err_count;
		passes = st.switch_en ? 2 : 1;
		pass = 0;
		w = 0;
		cur_song = int'(st.song);
		exp_nn = 2;
		s = 0;
		done_exp = -1;
		sd_exp = -1;
		p_start = -1;
		p_len = 0;
		half = 1;
		note_val = 0;
		run_start = 0;
		snd_prev = 1'b0;
		finished = 1'b0;
		n = 0;
		next_cycle(1'b1, st.song);
		while (!finished) begin
			check_val("new_note", 32'(new_note), 32'(n == exp_nn));
			if (n == exp_nn) begin
				ew = expected_word(cur_song, w);
				check_val("note_word", 32'(note_word), 32'(ew));
				s = n;
				note_val = int'(ew[11:6]);
				dur = int'(ew[5:0]);
				half = (note_val + 1) * TONE_DIV;
				done_exp = s + dur * BEAT_DIV;
				exp_nn = -1;
				// pause lands inside the note and stretches it cycle for cycle
				if (pass == 0 && w == int'(st.pause_word)) begin
					p_start = s + 1 + int'($urandom % (dur * BEAT_DIV));
					p_len = 1 + int'($urandom % MAX_PAUSE);
					done_exp += p_len;
				end
			end
			// square wave only while a pitched note runs with play held
			snd_exp = (done_exp >= 0) && (n > s) && (n <= done_exp) && play &&
				(note_val != 0);
			if (snd_exp && !snd_prev)
				run_start = n;
			snd_prev = snd_exp;
			check_val("tone", 32'(tone),
				snd_exp ? 32'(((n - run_start) / half) % 2) : 32'd0);
			check_val("note_done", 32'(note_done), 32'(n == done_exp));
			check_val("song_done", 32'(song_done), 32'(n == sd_exp));
			if (n == done_exp) begin
				done_exp = -1;
				if (w == WORDS - 1) begin
					// the restart after the last word picks up the new select
					sd_exp = n + 1;
					pass++;
					w = 0;
					if (pass < passes) begin
						cur_song = int'(st.switch_to);
						exp_nn = n + 4;
					end
				end else begin
					w++;
					exp_nn = n + 3;
				end
			end
			play_nxt = !(n + 1 >= p_start && n + 1 < p_start + p_len);
			song_nxt = song;
			// select moves halfway into the first pass
			if (st.switch_en && pass == 0 && w == WORDS / 2 && n == s)
				song_nxt = st.switch_to;
			// play drops once the last song ends so the reader must stay idle
			if (pass >= passes && n >= sd_exp) begin
				play_nxt = 1'b0;
				finished = (n >= sd_exp + 6);
			end
			if (!finished) begin
				next_cycle(play_nxt, song_nxt);
				n++;
			end
		end
		report(idx + 1, label, e0);
	endtask

	// twice the budget of the longest note per word plus the pauses
	initial begin
		int limit;
		limit = 2 * NUM_TESTS * (WORDS * (4 * BEAT_DIV + 3) + MAX_PAUSE) +
			RESET_CYCLES + IDLE_CYCLES;
		repeat (limit) @(posedge clk);
		$display("watchdog: the run did not end within %0d clock cycles", limit);
		$display("Some tests failed");
		$finish;
	end

	initial begin
		int unsigned seed_ret;
		int i;
		int e0;
		seed_ret = $urandom(32'haa51_1eb7);
		rst_n = 1'b0;
		play = 1'b0;
		song = '0;
		stim_table[0] = '{2'd0, 5'd3, 1'b0, 2'd0};
		stim_table[1] = '{2'd1, 5'd12, 1'b1, 2'd2};
		// word 7 is a rest
		stim_table[2] = '{2'd3, 5'd7, 1'b0, 2'd3};
		stim_table[3] = '{2'd2, 5'd30, 1'b0, 2'd2};
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// quiet with play low
		e0 = err_count;
		for (i = 0; i < IDLE_CYCLES; i++) begin
			next_cycle(1'b0, '0);
			check_val("new_note", 32'(new_note), 32'd0);
			check_val("song_done", 32'(song_done), 32'd0);
			check_val("tone", 32'(tone), 32'd0);
		end
		report(0, "idle after reset", e0);
		for (i = 0; i < NUM_TESTS; i++)
			run_entry(i);
		$display("tests: %0d run, %0d failed, %0d checks, %0d errors",
			NUM_TESTS + 1, fail_count, check_count, err_count);
		if (err_count == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tone_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tone_gen #(
	parameter int TONE_DIV = 1
) (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic sounding,
	input wire logic [music_pkg::NOTE_W-1:0] note,
	output logic tone
);

	import music_pkg::*;

	// wide enough for the longest half-period, 64 units
	localparam int CNT_W = $clog2((1 << NOTE_W) * TONE_DIV + 1);

	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cnt_eff;
	// half-period in clocks
	logic [CNT_W-1:0] half;
	logic [NOTE_W-1:0] note_q;
	logic note_chg;
	logic tone_q;

	assign half = (CNT_W'(note) + CNT_W'(1)) * CNT_W'(TONE_DIV);

	// a new note starts its half-period from scratch
	assign note_chg = (note != note_q);
	assign cnt_eff = note_chg ? '0 : cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			tone_q <= 1'b0;
			note_q <= '0;
		end else begin
			note_q <= note;
			if (!sounding) begin
				cnt <= '0;
				tone_q <= 1'b0;
			end else if (cnt_eff == half - CNT_W'(1)) begin
				cnt <= '0;
				tone_q <= ~tone_q;
			end else begin
				cnt <= cnt_eff + CNT_W'(1);
			end
		end
	end

	// mute at once when sounding drops, not a clock later
	assign tone = tone_q & sounding;

endmodule

`default_nettype wire
